// ==== int_divider.f ====
verilog/int_divider_pkg.sv
verilog/div_ctrl_if.sv
verilog/div_sequencer.sv
verilog/bit_counter.sv
verilog/div_datapath.sv
verilog/int_divider.sv
dv/int_divider_chk.sv
dv/int_divider_tb.sv

// ==== dv/int_divider_tb.sv ====
`default_nettype none

module int_divider_tb;

    localparam int operand_width   = 16;
    localparam int num_ops         = 200;
    localparam int reset_cycles    = 10;
    localparam int max_ack_delay   = 7;
    // worst case per operation plus reset
    localparam int watchdog_cycles =
        num_ops * (2 * operand_width + 1 + max_ack_delay + 4) + reset_cycles;

    logic                     clk_in;
    logic                     reset_in;
    logic                     valid_in;
    logic                     dividend_sign_in;
    logic [operand_width-1:0] dividend_in;
    logic                     divisor_sign_in;
    logic [operand_width-1:0] divisor_in;
    logic                     issue_ack_in;
    logic                     issue_ack_out;
    logic                     valid_out;
    logic                     quotient_sign_out;
    logic [operand_width-1:0] quotient_out;
    logic                     remainder_sign_out;
    logic [operand_width-1:0] remainder_out;
    logic                     divide_by_zero;

    logic [31:0] lcg_state;
    int          error_count;
    int          test_count;
    int          failed_tests;

    int_divider #(.operand_width(operand_width)) dut_i
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .valid_in           (valid_in),
        .dividend_sign_in   (dividend_sign_in),
        .dividend_in        (dividend_in),
        .divisor_sign_in    (divisor_sign_in),
        .divisor_in         (divisor_in),
        .issue_ack_in       (issue_ack_in),
        .issue_ack_out      (issue_ack_out),
        .valid_out          (valid_out),
        .quotient_sign_out  (quotient_sign_out),
        .quotient_out       (quotient_out),
        .remainder_sign_out (remainder_sign_out),
        .remainder_out      (remainder_out),
        .divide_by_zero     (divide_by_zero)
    );

    always #5 clk_in = ~clk_in;

    // 32-bit lcg, upper bits are the useful ones
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // all result outputs at once
    task automatic check_outputs(input logic exp_valid, input logic exp_dbz,
                                 input logic exp_qs, input logic [operand_width-1:0] exp_q,
                                 input logic exp_rs, input logic [operand_width-1:0] exp_r);
        compare("valid_out", exp_valid, valid_out);
        compare("divide_by_zero", exp_dbz, divide_by_zero);
        compare("quotient_sign_out", exp_qs, quotient_sign_out);
        compare("quotient_out", exp_q, quotient_out);
        compare("remainder_sign_out", exp_rs, remainder_sign_out);
        compare("remainder_out", exp_r, remainder_out);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic run_op(input int index);
        logic [31:0]              r1;
        logic [31:0]              r2;
        logic [31:0]              r3;
        logic [operand_width-1:0] dividend;
        logic [operand_width-1:0] divisor;
        logic                     dividend_sign;
        logic                     divisor_sign;
        logic                     hold_valid;
        logic [operand_width-1:0] exp_q;
        logic [operand_width-1:0] exp_r;
        logic                     exp_qs;
        logic                     exp_rs;
        logic                     exp_dbz;
        int                       exp_edges;
        int                       edges;
        int                       acks;
        int                       delay;
        int                       errors_before;
        errors_before = error_count;
        r1            = lcg_next();
        r2            = lcg_next();
        r3            = lcg_next();
        dividend      = r1[31:16];
        dividend_sign = r1[15];
        divisor       = r2[31:16];
        divisor_sign  = r2[14];
        // roughly one in eight divisors forced to zero
        if (r3[31:29] == 3'd0)
        begin
            divisor = '0;
        end
        delay      = r3[28:26];
        // some ops keep valid_in up through the busy period
        hold_valid = r3[25];

        // reference model
        if (divisor == 0)
        begin
            exp_dbz   = 1'b1;
            exp_q     = '0;
            exp_r     = '0;
            exp_qs    = 1'b0;
            exp_rs    = 1'b0;
            exp_edges = 1;
        end
        else
        begin
            exp_dbz   = 1'b0;
            exp_q     = dividend / divisor;
            exp_r     = dividend % divisor;
            exp_qs    = dividend_sign ^ divisor_sign;
            exp_rs    = divisor_sign;
            exp_edges = 2 * operand_width + 1;
        end

        @(posedge clk_in);
        valid_in         <= 1'b1;
        dividend_in      <= dividend;
        dividend_sign_in <= dividend_sign;
        divisor_in       <= divisor;
        divisor_sign_in  <= divisor_sign;
        // accept edge
        @(posedge clk_in);
        if (!hold_valid)
        begin
            valid_in <= 1'b0;
        end
        @(negedge clk_in);
        compare("issue_ack_out", 1, issue_ack_out);
        acks  = issue_ack_out;
        edges = 0;
        // edges from accept until valid_out, bounded
        while (!valid_out && edges < 4 * operand_width)
        begin
            @(posedge clk_in);
            edges++;
            @(negedge clk_in);
            acks += issue_ack_out;
        end
        compare("valid_out latency", exp_edges, edges);
        check_outputs(1'b1, exp_dbz, exp_qs, exp_q, exp_rs, exp_r);

        // back-pressure, results must not move
        repeat (delay)
        begin
            @(posedge clk_in);
            @(negedge clk_in);
            acks += issue_ack_out;
            check_outputs(1'b1, exp_dbz, exp_qs, exp_q, exp_rs, exp_r);
        end
        @(posedge clk_in);
        issue_ack_in <= 1'b1;
        valid_in     <= 1'b0;
        @(negedge clk_in);
        acks += issue_ack_out;
        check_outputs(1'b1, exp_dbz, exp_qs, exp_q, exp_rs, exp_r);
        // release edge
        @(posedge clk_in);
        issue_ack_in <= 1'b0;
        @(negedge clk_in);
        acks += issue_ack_out;
        check_outputs(1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        compare("issue_ack_out pulses", 1, acks);
        finish_test($sformatf("op %0d %h/%h", index, dividend, divisor), errors_before);
    endtask

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk_in);
        $display("run timed out after %0d cycles without finishing", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        int errors_before;
        clk_in           = 1'b0;
        reset_in         = 1'b1;
        valid_in         = 1'b0;
        dividend_sign_in = 1'b0;
        dividend_in      = '0;
        divisor_sign_in  = 1'b0;
        divisor_in       = '0;
        issue_ack_in     = 1'b0;
        lcg_state        = 32'd68;
        error_count      = 0;
        test_count       = 0;
        failed_tests     = 0;

        repeat (reset_cycles) @(posedge clk_in);
        reset_in <= 1'b0;
        @(negedge clk_in);
        errors_before = error_count;
        compare("issue_ack_out", 0, issue_ack_out);
        check_outputs(1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        finish_test("reset", errors_before);

        for (int i = 0; i < num_ops; i++)
        begin
            run_op(i);
        end

        // bound assertions count into the total
        error_count += dut_i.sequencer_i.chk_i.assert_failures;
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 test_count, failed_tests, error_count,
                 dut_i.sequencer_i.chk_i.assert_failures);
        if (error_count == 0 && failed_tests == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/int_divider_chk.sv ====
`default_nettype none

module int_divider_chk
    import int_divider_pkg::*;
(
    input logic       clk_in,
    input logic       reset_in,
    input logic       issue_ack_in,
    input logic       issue_ack_out,
    input logic       valid_out,
    input div_state_t state
);

    // failure count for the end of run summary
    int assert_failures = 0;

    // accept ack is a single-cycle pulse
    ack_single_cycle: assert property (
        @(posedge clk_in) disable iff (reset_in)
        issue_ack_out |=> !issue_ack_out
    )
    else
    begin
        $error("issue_ack_out stayed high for two cycles");
        assert_failures++;
    end

    // results held until the consumer acks
    valid_held: assert property (
        @(posedge clk_in) disable iff (reset_in)
        valid_out && !issue_ack_in |=> valid_out
    )
    else
    begin
        $error("valid_out dropped without issue_ack_in");
        assert_failures++;
    end

    // done / fault only left through the output handshake
    hold_state: assert property (
        @(posedge clk_in) disable iff (reset_in)
        ((state == st_done) || (state == st_fault)) && !issue_ack_in |=> $stable(state)
    )
    else
    begin
        $error("sequencer left done or fault without issue_ack_in");
        assert_failures++;
    end

endmodule

bind div_sequencer int_divider_chk chk_i
(
    .clk_in        (clk_in),
    .reset_in      (reset_in),
    .issue_ack_in  (issue_ack_in),
    .issue_ack_out (issue_ack_out),
    .valid_out     (valid_out),
    .state         (state)
);

`default_nettype wire

// ==== verilog/int_divider.sv ====
`default_nettype none

module int_divider
    import int_divider_pkg::*;
#(
    parameter int operand_width = default_operand_width
)
(
    input  logic                     clk_in,
    input  logic                     reset_in,
    input  logic                     valid_in,
    input  logic                     dividend_sign_in,
    input  logic [operand_width-1:0] dividend_in,
    input  logic                     divisor_sign_in,
    input  logic [operand_width-1:0] divisor_in,
    input  logic                     issue_ack_in,
    output logic                     issue_ack_out,
    output logic                     valid_out,
    output logic                     quotient_sign_out,
    output logic [operand_width-1:0] quotient_out,
    output logic                     remainder_sign_out,
    output logic [operand_width-1:0] remainder_out,
    output logic                     divide_by_zero
);

    // sequencer to counter
    logic count_clear;
    logic count_step;
    logic last_bit;

    // step commands and divisor status
    div_ctrl_if ctrl_i ();

    div_sequencer sequencer_i
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .valid_in      (valid_in),
        .issue_ack_in  (issue_ack_in),
        .last_bit      (last_bit),
        .issue_ack_out (issue_ack_out),
        .valid_out     (valid_out),
        .count_clear   (count_clear),
        .count_step    (count_step),
        .ctrl          (ctrl_i.seq)
    );

    // width lives here only, the sequencer just sees last_bit
    bit_counter #(.operand_width(operand_width)) counter_i
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .count_clear (count_clear),
        .count_step  (count_step),
        .last_bit    (last_bit)
    );

    div_datapath #(.operand_width(operand_width)) datapath_i
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .dividend_sign_in   (dividend_sign_in),
        .dividend_in        (dividend_in),
        .divisor_sign_in    (divisor_sign_in),
        .divisor_in         (divisor_in),
        .quotient_sign_out  (quotient_sign_out),
        .quotient_out       (quotient_out),
        .remainder_sign_out (remainder_sign_out),
        .remainder_out      (remainder_out),
        .divide_by_zero     (divide_by_zero),
        .ctrl               (ctrl_i.dp)
    );

endmodule

`default_nettype wire

// ==== verilog/div_datapath.sv ====
`default_nettype none

module div_datapath
    import int_divider_pkg::*;
#(
    parameter int operand_width = default_operand_width
)
(
    input  logic                     clk_in,
    input  logic                     reset_in,
    input  logic                     dividend_sign_in,
    input  logic [operand_width-1:0] dividend_in,
    input  logic                     divisor_sign_in,
    input  logic [operand_width-1:0] divisor_in,
    output logic                     quotient_sign_out,
    output logic [operand_width-1:0] quotient_out,
    output logic                     remainder_sign_out,
    output logic [operand_width-1:0] remainder_out,
    output logic                     divide_by_zero,
    div_ctrl_if.dp                   ctrl
);

    logic                     dividend_sign_q;
    logic                     divisor_sign_q;
    logic [operand_width-1:0] divisor_q;

    // partial remainder on top, quotient on the bottom
    // extra msb keeps the bit shifted out of the remainder half
    logic [2*operand_width:0] rem_quot;

    logic [operand_width:0]   upper;
    logic [operand_width+1:0] diff;
    logic                     borrow;

    // checked by the sequencer at the accept edge
    assign ctrl.divisor_zero = ~(|divisor_in);

    // trial subtract
    assign upper  = rem_quot[2*operand_width:operand_width];
    assign diff   = {1'b0, upper} - {2'b00, divisor_q};
    assign borrow = diff[operand_width+1];

    always_ff @(posedge clk_in)
    begin
        if (ctrl.load)
        begin
            dividend_sign_q <= dividend_sign_in;
            divisor_sign_q  <= divisor_sign_in;
            divisor_q       <= divisor_in;
            rem_quot        <= {{(operand_width + 1){1'b0}}, dividend_in};
        end
        else if (ctrl.shift)
        begin
            rem_quot <= {rem_quot[2*operand_width-1:0], 1'b0};
        end
        else if (ctrl.subtract)
        begin
            // restore by not writing back when the subtract borrows
            if (!borrow)
            begin
                rem_quot[2*operand_width:operand_width] <= diff[operand_width:0];
            end
            // new quotient bit into the slot freed by the shift
            rem_quot[0] <= ~borrow;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            quotient_sign_out  <= 1'b0;
            quotient_out       <= '0;
            remainder_sign_out <= 1'b0;
            remainder_out      <= '0;
            divide_by_zero     <= 1'b0;
        end
        else if (ctrl.publish)
        begin
            // quotient sign from both inputs, remainder follows divisor
            quotient_sign_out  <= dividend_sign_q ^ divisor_sign_q;
            quotient_out       <= rem_quot[operand_width-1:0];
            remainder_sign_out <= divisor_sign_q;
            remainder_out      <= rem_quot[2*operand_width-1:operand_width];
            divide_by_zero     <= 1'b0;
        end
        else if (ctrl.fault)
        begin
            // divide by zero, zero results with the flag
            quotient_sign_out  <= 1'b0;
            quotient_out       <= '0;
            remainder_sign_out <= 1'b0;
            remainder_out      <= '0;
            divide_by_zero     <= 1'b1;
        end
        else if (ctrl.release_hold)
        begin
            quotient_sign_out  <= 1'b0;
            quotient_out       <= '0;
            remainder_sign_out <= 1'b0;
            remainder_out      <= '0;
            divide_by_zero     <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bit_counter.sv ====
`default_nettype none

module bit_counter
    import int_divider_pkg::*;
#(
    parameter int operand_width = default_operand_width
)
(
    input  logic clk_in,
    input  logic reset_in,
    input  logic count_clear,
    input  logic count_step,
    output logic last_bit
);

    localparam int count_bits = count_width_f(operand_width);

    // quotient bits shifted in so far
    logic [count_bits-1:0] count;

    // all bits done once the count reaches the width
    assign last_bit = (count == count_bits'(operand_width));

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            count <= '0;
        end
        else if (count_clear)
        begin
            count <= '0;
        end
        else if (count_step)
        begin
            count <= count + count_bits'(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/div_sequencer.sv ====
`default_nettype none

module div_sequencer
    import int_divider_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset_in,
    input  logic      valid_in,
    input  logic      issue_ack_in,
    input  logic      last_bit,
    output logic      issue_ack_out,
    output logic      valid_out,
    output logic      count_clear,
    output logic      count_step,
    div_ctrl_if.seq   ctrl
);

    div_state_t state;
    div_state_t state_next;

    logic accept;
    logic holding;

    // operands taken only from idle
    assign accept = (state == st_idle) && valid_in;

    // done or fault with results already on the outputs
    assign holding = ((state == st_done) || (state == st_fault)) && valid_out;

    // command decode
    assign ctrl.load         = accept;
    assign ctrl.shift        = (state == st_shift);
    assign ctrl.subtract     = (state == st_subtract);
    // first cycle of done / fault only, valid_out still low
    assign ctrl.publish      = (state == st_done) && !valid_out;
    assign ctrl.fault        = (state == st_fault) && !valid_out;
    // issue_ack_in ignored until valid_out is up
    assign ctrl.release_hold = holding && issue_ack_in;

    // counter restarts on accept, one step per shift
    assign count_clear = accept;
    assign count_step  = ctrl.shift;

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (accept)
                begin
                    // zero divisor skips the iteration
                    state_next = ctrl.divisor_zero ? st_fault : st_shift;
                end
            end
            st_shift:
            begin
                state_next = st_subtract;
            end
            st_subtract:
            begin
                // last quotient bit just resolved
                state_next = last_bit ? st_done : st_shift;
            end
            st_done, st_fault:
            begin
                if (ctrl.release_hold)
                begin
                    state_next = st_idle;
                end
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state         <= st_idle;
            issue_ack_out <= 1'b0;
            valid_out     <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            // single-cycle pulse right after the accept edge
            issue_ack_out <= accept;
            if (ctrl.publish || ctrl.fault)
            begin
                valid_out <= 1'b1;
            end
            else if (ctrl.release_hold)
            begin
                valid_out <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/div_ctrl_if.sv ====
`default_nettype none

interface div_ctrl_if;

    // step commands, one-hot, each acts on the edge where it is high
    logic load;
    logic shift;
    logic subtract;
    logic publish;
    logic fault;
    // clears the result registers after the output handshake
    logic release_hold;

    // status back to the sequencer
    logic divisor_zero;

    modport seq
    (
        output load, shift, subtract, publish, fault, release_hold,
        input  divisor_zero
    );

    modport dp
    (
        input  load, shift, subtract, publish, fault, release_hold,
        output divisor_zero
    );

endinterface

`default_nettype wire

// ==== verilog/int_divider_pkg.sv ====
`default_nettype none

package int_divider_pkg;

    // magnitude width when the top level does not override it
    localparam int default_operand_width = 32;

    // sequencer states
    // idle waits for valid_in, done and fault hold the results
    typedef enum logic [2:0]
    {
        st_idle     = 3'd0,
        st_shift    = 3'd1,
        st_subtract = 3'd2,
        st_done     = 3'd3,
        st_fault    = 3'd4
    } div_state_t;

    // counter bits needed to reach width itself
    function automatic int count_width_f(input int width);
        return $clog2(width + 1);
    endfunction

endpackage

`default_nettype wire
